// File: logic/rf_pkg.sv
////////////////////
// shared widths and types of the register read and writeback path
// reg_idx_t is fixed at 5 bits, so reg_count cannot go above 32
// register 0 is hardwired to zero in every reader
////////////////////
`default_nettype none

package rf_pkg;

	////////////////////
	// widths and counts
	////////////////////
	localparam int xlen      = 64; // register data width
	localparam int reg_count = 32; // architectural registers

	////////////////////
	// types
	////////////////////
	typedef logic [xlen-1:0] xlen_t;   // one register value
	typedef logic [4:0]      reg_idx_t; // register name

	// hardwired zero register
	localparam reg_idx_t zero_reg = 5'd0;

endpackage

`default_nettype wire

// File: logic/rf_read_if.sv
////////////////////
// one read port pair between an issuing way and the register file
// purely combinational, no handshake
// data is valid in the same cycle as the indices
////////////////////
`default_nettype none

interface rf_read_if #(
	parameter int XLEN = rf_pkg::xlen
) ();
	import rf_pkg::*;

	reg_idx_t idx_a;  // first source
	reg_idx_t idx_b;  // second source
	xlen_t    data_a; // value of idx_a, forwarded if written this cycle
	xlen_t    data_b; // value of idx_b

	if (XLEN != $bits(xlen_t)) begin : g_width_check
		$error("rf_read_if: XLEN differs from rf_pkg::xlen");
	end

	modport reader  (output idx_a, output idx_b, input  data_a, input  data_b);
	modport regfile (input  idx_a, input  idx_b, output data_a, output data_b);

endinterface

`default_nettype wire

// File: logic/regfile.sv
////////////////////
// 32 x XLEN register file, four combinational reads, two writes
// reads see writes of the same cycle, way 1 before way 0
// both writes to one index: way 1 is stored
// contents are undefined after reset, write a register before use
// writers never target register 0
////////////////////
`default_nettype none

module regfile #(
	parameter int XLEN = rf_pkg::xlen
) (
	input  logic             clock,

	rf_read_if.regfile       rd_0,      // way 0 sources
	rf_read_if.regfile       rd_1,      // way 1 sources

	input  logic             wr_en_0,
	input  logic             wr_en_1,
	input  rf_pkg::reg_idx_t wr_idx_0,
	input  rf_pkg::reg_idx_t wr_idx_1,
	input  rf_pkg::xlen_t    wr_data_0,
	input  rf_pkg::xlen_t    wr_data_1
);
	import rf_pkg::*;

	logic [XLEN-1:0] regs [reg_count]; // architectural state, entry 0 unused

	if (XLEN != $bits(xlen_t)) begin : g_width_check
		$error("regfile: XLEN differs from rf_pkg::xlen");
	end

	////////////////////
	// read side
	////////////////////

	// one read port: zero reg, then way 1 bypass, then way 0, then storage
	function automatic xlen_t read_port(input reg_idx_t idx);
		xlen_t val;
		if (idx == zero_reg) begin
			val = '0;               // hardwired zero
		end else if (wr_en_1 && (wr_idx_1 == idx)) begin
			val = wr_data_1;        // way 1 wins, same as on write
		end else if (wr_en_0 && (wr_idx_0 == idx)) begin
			val = wr_data_0;        // way 0 bypass
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_comb begin
		rd_0.data_a = read_port(rd_0.idx_a);
		rd_0.data_b = read_port(rd_0.idx_b);
		rd_1.data_a = read_port(rd_1.idx_a);
		rd_1.data_b = read_port(rd_1.idx_b);
	end

	////////////////////
	// write side
	////////////////////
	always_ff @(posedge clock) begin
		if (wr_en_0) begin
			regs[wr_idx_0] <= wr_data_0;
		end
		if (wr_en_1) begin
			regs[wr_idx_1] <= wr_data_1; // later NBA, overrides way 0 on a tie
		end
	end

	////////////////////
	// checks
	////////////////////

	// writeback_stage filters register 0 before it reaches these ports
	a_no_zero_write_0 : assert property (@(posedge clock)
		wr_en_0 |-> (wr_idx_0 != zero_reg))
		else $error("regfile: way 0 write to register 0");

	a_no_zero_write_1 : assert property (@(posedge clock)
		wr_en_1 |-> (wr_idx_1 != zero_reg))
		else $error("regfile: way 1 write to register 0");

endmodule

`default_nettype wire

// File: logic/operand_stage.sv
////////////////////
// issue to execute register for two ways, one cycle latency
// stall holds valid and source indices, new issues are dropped
// operands reload every cycle, so a held op follows later writebacks
////////////////////
`default_nettype none

module operand_stage #(
	parameter int XLEN = rf_pkg::xlen
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             stall,

	input  logic             issue_valid_0,
	input  logic             issue_valid_1,
	input  rf_pkg::reg_idx_t issue_rs1_0,
	input  rf_pkg::reg_idx_t issue_rs2_0,
	input  rf_pkg::reg_idx_t issue_rs1_1,
	input  rf_pkg::reg_idx_t issue_rs2_1,

	rf_read_if.reader        rd_0,
	rf_read_if.reader        rd_1,

	output logic             op_valid_0,
	output logic             op_valid_1,
	output rf_pkg::xlen_t    op_a_0,
	output rf_pkg::xlen_t    op_b_0,
	output rf_pkg::xlen_t    op_a_1,
	output rf_pkg::xlen_t    op_b_1
);
	import rf_pkg::*;

	reg_idx_t rs1_q_0; // held sources of way 0
	reg_idx_t rs2_q_0;
	reg_idx_t rs1_q_1; // held sources of way 1
	reg_idx_t rs2_q_1;

	if (XLEN != $bits(xlen_t)) begin : g_width_check
		$error("operand_stage: XLEN differs from rf_pkg::xlen");
	end

	////////////////////
	// read index select
	////////////////////
	assign rd_0.idx_a = stall ? rs1_q_0 : issue_rs1_0; // re-read held op
	assign rd_0.idx_b = stall ? rs2_q_0 : issue_rs2_0;
	assign rd_1.idx_a = stall ? rs1_q_1 : issue_rs1_1;
	assign rd_1.idx_b = stall ? rs2_q_1 : issue_rs2_1;

	////////////////////
	// pipeline register
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			op_valid_0 <= 1'b0;
			op_valid_1 <= 1'b0;
		end else if (!stall) begin
			op_valid_0 <= issue_valid_0; // held while stalled
			op_valid_1 <= issue_valid_1;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			rs1_q_0 <= issue_rs1_0; // accept new instruction
			rs2_q_0 <= issue_rs2_0;
			rs1_q_1 <= issue_rs1_1;
			rs2_q_1 <= issue_rs2_1;
		end
		op_a_0 <= rd_0.data_a; // refreshed every cycle, stalled or not
		op_b_0 <= rd_0.data_b;
		op_a_1 <= rd_1.data_a;
		op_b_1 <= rd_1.data_b;
	end

	// a stalled edge must leave the issued instruction in place
	a_hold_on_stall : assert property (@(posedge clock) disable iff (reset)
		(stall && !reset) |=> ($stable(op_valid_0) && $stable(op_valid_1)))
		else $error("operand_stage: op_valid changed under stall");

endmodule

`default_nettype wire

// File: logic/writeback_stage.sv
////////////////////
// registers two completing results and drives the regfile writes
// never stalls, a result is accepted at every edge
// results to register 0 are dropped here
////////////////////
`default_nettype none

module writeback_stage #(
	parameter int XLEN = rf_pkg::xlen
) (
	input  logic             clock,
	input  logic             reset,

	input  logic             wb_valid_0,
	input  logic             wb_valid_1,
	input  rf_pkg::reg_idx_t wb_dest_0,
	input  rf_pkg::reg_idx_t wb_dest_1,
	input  rf_pkg::xlen_t    wb_data_0,
	input  rf_pkg::xlen_t    wb_data_1,

	output logic             wr_en_0,
	output logic             wr_en_1,
	output rf_pkg::reg_idx_t wr_idx_0,
	output rf_pkg::reg_idx_t wr_idx_1,
	output rf_pkg::xlen_t    wr_data_0,
	output rf_pkg::xlen_t    wr_data_1
);
	import rf_pkg::*;

	if (XLEN != $bits(xlen_t)) begin : g_width_check
		$error("writeback_stage: XLEN differs from rf_pkg::xlen");
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_en_0 <= 1'b0;
			wr_en_1 <= 1'b0;
		end else begin
			wr_en_0 <= wb_valid_0 && (wb_dest_0 != zero_reg); // zero reg filtered
			wr_en_1 <= wb_valid_1 && (wb_dest_1 != zero_reg);
		end
	end

	always_ff @(posedge clock) begin
		wr_idx_0  <= wb_dest_0; // payload, qualified by wr_en
		wr_idx_1  <= wb_dest_1;
		wr_data_0 <= wb_data_0;
		wr_data_1 <= wb_data_1;
	end

endmodule

`default_nettype wire

// File: logic/regfile_subsystem.sv
////////////////////
// register read and writeback subsystem of a two-wide pipeline
// issue to operands: one cycle; result to register: one cycle
// stall comes from outside and only affects the operand stage
////////////////////
`default_nettype none

module regfile_subsystem #(
	parameter int XLEN = rf_pkg::xlen
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             stall,

	input  logic             issue_valid_0,
	input  logic             issue_valid_1,
	input  rf_pkg::reg_idx_t issue_rs1_0,
	input  rf_pkg::reg_idx_t issue_rs2_0,
	input  rf_pkg::reg_idx_t issue_rs1_1,
	input  rf_pkg::reg_idx_t issue_rs2_1,

	input  logic             wb_valid_0,
	input  logic             wb_valid_1,
	input  rf_pkg::reg_idx_t wb_dest_0,
	input  rf_pkg::reg_idx_t wb_dest_1,
	input  rf_pkg::xlen_t    wb_data_0,
	input  rf_pkg::xlen_t    wb_data_1,

	output logic             op_valid_0,
	output logic             op_valid_1,
	output rf_pkg::xlen_t    op_a_0,
	output rf_pkg::xlen_t    op_b_0,
	output rf_pkg::xlen_t    op_a_1,
	output rf_pkg::xlen_t    op_b_1
);
	import rf_pkg::*;

	////////////////////
	// internal wiring
	////////////////////
	logic     wr_en_0;   // writeback to regfile
	logic     wr_en_1;
	reg_idx_t wr_idx_0;
	reg_idx_t wr_idx_1;
	xlen_t    wr_data_0;
	xlen_t    wr_data_1;

	rf_read_if #(.XLEN(XLEN)) read_0 (); // way 0 sources
	rf_read_if #(.XLEN(XLEN)) read_1 (); // way 1 sources

	////////////////////
	// blocks
	////////////////////
	operand_stage #(.XLEN(XLEN)) u_operand_stage (
		.clock, .reset, .stall,
		.issue_valid_0, .issue_valid_1,
		.issue_rs1_0, .issue_rs2_0, .issue_rs1_1, .issue_rs2_1,
		.rd_0 (read_0.reader),
		.rd_1 (read_1.reader),
		.op_valid_0, .op_valid_1,
		.op_a_0, .op_b_0, .op_a_1, .op_b_1
	);

	regfile #(.XLEN(XLEN)) u_regfile (
		.clock,
		.rd_0 (read_0.regfile),
		.rd_1 (read_1.regfile),
		.wr_en_0, .wr_en_1, .wr_idx_0, .wr_idx_1, .wr_data_0, .wr_data_1
	);

	writeback_stage #(.XLEN(XLEN)) u_writeback_stage (
		.clock, .reset,
		.wb_valid_0, .wb_valid_1, .wb_dest_0, .wb_dest_1, .wb_data_0, .wb_data_1,
		.wr_en_0, .wr_en_1, .wr_idx_0, .wr_idx_1, .wr_data_0, .wr_data_1
	);

endmodule

`default_nettype wire

// File: tests/tb_regfile_subsystem.sv
////////////////////
// one stimulus table row per clock cycle
// inputs change on the falling edge and outputs are checked one falling edge later
// registers are not reset so test 2 fills all of them before any random read
////////////////////
`default_nettype none

module tb_regfile_subsystem;
	import rf_pkg::*;

	typedef struct packed {
		int                 test;  // test number from 1 to 6
		logic               stall;
		logic [1:0]         iv;    // issue valid per way
		reg_idx_t [3:0]     src;   // rs1_0, rs2_0, rs1_1, rs2_1
		logic [1:0]         wv;    // result valid per way
		reg_idx_t [1:0]     dest;
		xlen_t [1:0]        data;
	} row_t;

	logic     clock, reset, stall;
	logic     issue_valid_0, issue_valid_1, wb_valid_0, wb_valid_1;
	reg_idx_t issue_rs1_0, issue_rs2_0, issue_rs1_1, issue_rs2_1;
	reg_idx_t wb_dest_0, wb_dest_1;
	xlen_t    wb_data_0, wb_data_1;
	logic     op_valid_0, op_valid_1;
	xlen_t    op_a_0, op_b_0, op_a_1, op_b_1;

	row_t           rows [$];             // stimulus table
	row_t           cur;                  // row being built
	xlen_t          model [reg_count];    // values a read sees this cycle
	logic [1:0]     exp_valid;
	reg_idx_t [3:0] held;                 // sources held by the operand stage
	xlen_t [3:0]    exp_op;
	logic [31:0]    lcg_state;
	int             checks_by_test [1:6];
	int             errors_by_test [1:6];
	string          test_names [1:6] = '{"reset and zero register", "write then read",
		"forwarding", "same destination", "stall and refresh", "random burst"};

	regfile_subsystem #(.XLEN(xlen)) uut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // period 40
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic xlen_t rand_data();
		return {lcg_next(), lcg_next()};
	endfunction

	function automatic xlen_t model_read(input reg_idx_t idx);
		return (idx == zero_reg) ? '0 : model[idx]; // register 0 reads zero
	endfunction

	task automatic set_issue(input logic v0, input reg_idx_t a0, b0,
			input logic v1, input reg_idx_t a1, b1);
		cur.iv  = {v1, v0};
		cur.src = {b1, a1, b0, a0};
	endtask

	task automatic set_result(input logic v0, input reg_idx_t d0, input xlen_t x0,
			input logic v1, input reg_idx_t d1, input xlen_t x1);
		cur.wv   = {v1, v0};
		cur.dest = {d1, d0};
		cur.data = {x1, x0};
	endtask

	task automatic push_row(input int test, input logic stall_bit);
		cur.test  = test;
		cur.stall = stall_bit;
		rows.push_back(cur);
		cur = '0; // next row starts idle
	endtask

	task automatic drive_row(input row_t r);
		stall         = r.stall;
		issue_valid_0 = r.iv[0];
		issue_valid_1 = r.iv[1];
		issue_rs1_0   = r.src[0];
		issue_rs2_0   = r.src[1];
		issue_rs1_1   = r.src[2];
		issue_rs2_1   = r.src[3];
		wb_valid_0    = r.wv[0];
		wb_valid_1    = r.wv[1];
		wb_dest_0     = r.dest[0];
		wb_dest_1     = r.dest[1];
		wb_data_0     = r.data[0];
		wb_data_1     = r.data[1];
	endtask

	// predicts the outputs after the next rising edge and commits the row's results
	task automatic model_step(input row_t r);
		if (!r.stall) begin
			exp_valid = r.iv; // new instruction accepted
			held      = r.src;
		end
		for (int p = 0; p < 4; p++) exp_op[p] = model_read(held[p]);
		for (int w = 0; w < 2; w++) begin
			if (r.wv[w] && (r.dest[w] != zero_reg)) begin
				model[r.dest[w]] = r.data[w]; // way 1 last
			end
		end
	endtask

	task automatic check_outputs(input int test);
		xlen_t [3:0] got;
		got = {op_b_1, op_a_1, op_b_0, op_a_0};
		checks_by_test[test] += 1;
		if ({op_valid_1, op_valid_0} !== exp_valid) begin
			$display("error: time %0t, op_valid is %b, expected %b", $time,
				{op_valid_1, op_valid_0}, exp_valid);
			errors_by_test[test] += 1;
		end
		for (int p = 0; p < 4; p++) begin
			if (exp_valid[p / 2] && (got[p] !== exp_op[p])) begin
				$display("error: time %0t, way %0d operand %0d is %h, expected %h",
					$time, p / 2, p % 2, got[p], exp_op[p]);
				errors_by_test[test] += 1;
			end
		end
	endtask

	task automatic report_test(input int test);
		$display("test %0d, %s: %0d checks, %0d errors", test, test_names[test],
			checks_by_test[test], errors_by_test[test]);
	endtask

	task automatic build_table();
		int          k;
		logic [31:0] r;
		set_result(1'b1, 5'd0, rand_data(), 1'b1, 5'd0, rand_data()); // dropped results
		push_row(1, 1'b0);
		set_issue(1'b1, 5'd0, 5'd0, 1'b1, 5'd0, 5'd0);
		push_row(1, 1'b0);
		set_issue(1'b1, 5'd0, 5'd0, 1'b1, 5'd0, 5'd0);
		push_row(1, 1'b0);
		for (k = 1; k < 32; k += 2) begin // fill every register
			set_result(1'b1, reg_idx_t'(k), rand_data(),
				(k < 31), reg_idx_t'(k + 1), rand_data());
			push_row(2, 1'b0);
		end
		push_row(2, 1'b0);
		push_row(2, 1'b0);
		for (k = 0; k < 8; k++) begin
			set_issue(1'b1, reg_idx_t'(4 * k + 1), reg_idx_t'(4 * k + 2),
				1'b1, reg_idx_t'(4 * k + 3), reg_idx_t'(4 * k + 4));
			push_row(2, 1'b0);
		end
		set_result(1'b1, 5'd5, rand_data(), 1'b1, 5'd6, rand_data());
		for (k = 0; k < 3; k++) begin // reads in the same cycle, forwarded and stored
			set_issue(1'b1, 5'd5, 5'd6, 1'b1, 5'd6, 5'd5);
			push_row(3, 1'b0);
		end
		set_result(1'b1, 5'd7, rand_data(), 1'b1, 5'd7, rand_data()); // way 1 must win
		push_row(4, 1'b0);
		for (k = 0; k < 2; k++) begin
			set_issue(1'b1, 5'd7, 5'd7, 1'b1, 5'd7, 5'd7);
			push_row(4, 1'b0);
		end
		set_issue(1'b1, 5'd9, 5'd10, 1'b1, 5'd11, 5'd9);
		push_row(5, 1'b0);
		set_issue(1'b1, 5'd1, 5'd2, 1'b0, 5'd3, 5'd4);       // ignored under stall
		set_result(1'b1, 5'd9, rand_data(), 1'b0, 5'd0, '0); // held sources follow this
		push_row(5, 1'b1);
		push_row(5, 1'b1);
		push_row(5, 1'b1);
		push_row(5, 1'b0);
		for (k = 0; k < 64; k++) begin
			r = lcg_next();
			set_issue(r[31], r[29:25], r[24:20], r[30], r[19:15], r[14:10]); // upper bits
			r = lcg_next();
			set_result(r[31], r[29:25], rand_data(), r[30], r[24:20], rand_data());
			push_row(6, (r[19:18] == 2'b00)); // stall about one cycle in four
		end
	endtask

	initial begin
		int   i;
		int   prev;
		int   wait_count;
		int   failed;
		logic timed_out;
		lcg_state = 32'h18de_5e5d;
		timed_out = 1'b0;
		failed    = 0;
		cur       = '0;
		exp_valid = '0;
		held      = '0;
		reset     = 1'b1;
		drive_row('0);
		issue_valid_0 = 1'b1; // pending issues that reset has to override
		issue_valid_1 = 1'b1;
		foreach (checks_by_test[t]) checks_by_test[t] = 0;
		foreach (errors_by_test[t]) errors_by_test[t] = 0;
		build_table();
		repeat (8) @(posedge clock);
		@(negedge clock);
		checks_by_test[1] += 1;
		if ((op_valid_0 !== 1'b0) || (op_valid_1 !== 1'b0)) begin
			$display("error: time %0t, op_valid set after reset", $time);
			errors_by_test[1] += 1;
		end
		reset = 1'b0;
		drive_row('0);
		@(negedge clock);
		prev = rows[0].test;
		for (i = 0; i < rows.size(); i++) begin
			if (i > 0) begin
				check_outputs(prev); // previous row after its rising edge
				if (rows[i].test != prev) report_test(prev);
			end
			drive_row(rows[i]);
			model_step(rows[i]);
			prev = rows[i].test;
			@(negedge clock);
		end
		check_outputs(prev);
		report_test(prev);
		drive_row('0);
		wait_count = 0;
		while ((op_valid_0 || op_valid_1) && (wait_count < 20)) begin // drain
			@(negedge clock);
			wait_count++;
		end
		if (op_valid_0 || op_valid_1) begin
			$display("timeout: op_valid still set 20 cycles after the last issue");
			timed_out = 1'b1;
		end
		foreach (errors_by_test[t]) begin
			if (errors_by_test[t] != 0) failed++;
		end
		$display("summary: %0d tests passed, %0d tests failed", 6 - failed, failed);
		if ((failed == 0) && !timed_out) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: regfile_subsystem.f
logic/rf_pkg.sv
logic/rf_read_if.sv
logic/regfile.sv
logic/operand_stage.sv
logic/writeback_stage.sv
logic/regfile_subsystem.sv
tests/tb_regfile_subsystem.sv

// File: Makefile
# Verilator lint and simulation of the register read and writeback subsystem
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_regfile_subsystem
FILELIST  = regfile_subsystem.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the outcome, a crash without a result line also fails
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
